//--- tb.f
+incdir+hw
hw/alu_pkg.sv
hw/axil_pkg.sv
hw/long_div.sv
hw/multi.sv
hw/alu.sv
hw/alu_regs.sv
hw/alu_top.sv
tb/alu_asserts.sv
tb/alu_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f tb.f --top-module alu_tb -o alu_sim \
	&& ./obj_dir/alu_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log \
	&& { echo "simulation reported errors"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }

//--- tb/alu_tb.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb import alu_pkg::*; import axil_pkg::*; ();

	localparam int W          = `ALU_XLEN;
	localparam int WAIT_LIMIT = 50; // cycles per handshake.
	localparam int POLL_LIMIT = 40; // status reads per operation.

	localparam logic [`AXIL_AW-1:0] A_OPA    = 'h00;
	localparam logic [`AXIL_AW-1:0] A_OPB    = 'h04;
	localparam logic [`AXIL_AW-1:0] A_OP     = 'h08;
	localparam logic [`AXIL_AW-1:0] A_STATUS = 'h0C;
	localparam logic [`AXIL_AW-1:0] A_RESULT = 'h10;

	logic     clk = 1'b0;
	logic     arst_n;
	axil_aw_t aw;
	logic     awvalid;
	logic     awready;
	axil_w_t  w;
	logic     wvalid;
	logic     wready;
	axil_b_t  b;
	logic     bvalid;
	logic     bready;
	axil_ar_t ar;
	logic     arvalid;
	logic     arready;
	axil_r_t  r;
	logic     rvalid;
	logic     rready;

	int     errors;
	int     checks;
	int     tests;
	integer seed;

	always #20 clk = ~clk;

	alu_top u_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [W-1:0] exp,
		input logic [W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_taken(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("timeout: %s was never seen", what);
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		$display("test %s: %s", name, (errors == e0) ? "ok" : "FAILED");
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic alu_res_t model(alu_op_e op, logic [W-1:0] a, logic [W-1:0] b);
		alu_res_t    exp;
		longint      sa;
		longint      sb;
		longint      ub;
		longint      q;
		logic [63:0] p;
		logic        ovf;
		exp = '0;
		sa  = $signed(a);
		sb  = $signed(b);
		ub  = {32'd0, b};
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			OP_ADD: exp.value = a + b;
			OP_SUB: exp.value = a - b;
			OP_SLL: exp.value = a << b[`ALU_SHW-1:0];
			OP_SRL: exp.value = a >> b[`ALU_SHW-1:0];
			OP_SRA: exp.value = $signed(a) >>> b[`ALU_SHW-1:0];
			OP_AND: exp.value = a & b;
			OP_OR: exp.value = a | b;
			OP_XOR: exp.value = a ^ b;
			OP_SLT: exp.value = (sa < sb) ? 1 : 0;
			OP_SLTU: exp.value = (a < b) ? 1 : 0;
			OP_MUL, OP_MULH: begin
				p = sa * sb;
				exp.value = (op == OP_MUL) ? p[31:0] : p[63:32];
			end
			OP_MULHSU: begin
				p = sa * ub;
				exp.value = p[63:32];
			end
			OP_MULHU: begin
				p = {32'd0, a} * {32'd0, b};
				exp.value = p[63:32];
			end
			OP_DIV, OP_REM: begin
				if (b == '0) begin
					exp.value = (op == OP_DIV) ? '1 : a; // divide by zero.
				end else if (ovf) begin
					exp.value = (op == OP_DIV) ? a : '0;
				end else begin
					q = (op == OP_DIV) ? sa / sb : sa % sb; // truncates toward zero.
					exp.value = q[31:0];
				end
			end
			OP_DIVU: exp.value = (b == '0) ? '1 : a / b;
			OP_REMU: exp.value = (b == '0) ? a : a % b;
			OP_BEQ: exp.taken = (a == b);
			OP_BNE: exp.taken = (a != b);
			OP_BLT: exp.taken = (sa < sb);
			OP_BGE: exp.taken = (sa >= sb);
			OP_BLTU: exp.taken = (a < b);
			OP_BGEU: exp.taken = (a >= b);
			default: ;
		endcase
		return exp;
	endfunction

	// ------------------------------------------------------------
	// host bus tasks
	// ------------------------------------------------------------
	task automatic axil_write(input logic [`AXIL_AW-1:0] addr, input logic [W-1:0] data,
		output axil_resp_e resp);
		int n;
		@(posedge clk);
		aw      <= '{addr: addr};
		w       <= '{data: data, strb: '1};
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!(awready && wready) && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!(awready && wready)) begin
			note_timeout("awready and wready");
		end
		@(posedge clk); // address and data taken here.
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!bvalid && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!bvalid) begin
			note_timeout("bvalid");
		end
		resp = b.resp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [`AXIL_AW-1:0] addr, output logic [W-1:0] data,
		output axil_resp_e resp);
		int n;
		@(posedge clk);
		ar      <= '{addr: addr};
		arvalid <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!arready && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!arready) begin
			note_timeout("arready");
		end
		@(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!rvalid && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!rvalid) begin
			note_timeout("rvalid");
		end
		data = r.data;
		resp = r.resp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic wait_done(output logic [W-1:0] status);
		axil_resp_e resp;
		int         n;
		n = 0;
		axil_read(A_STATUS, status, resp);
		while (!status[1] && n < POLL_LIMIT) begin
			n++;
			axil_read(A_STATUS, status, resp);
		end
		if (!status[1]) begin
			note_timeout("STATUS.done");
		end
	endtask

	task automatic verify_op(input alu_op_e op, input logic [W-1:0] a, input logic [W-1:0] b);
		axil_resp_e   resp;
		alu_res_t     exp;
		logic [W-1:0] status;
		logic [W-1:0] value;
		string        name;
		name = $sformatf("%s %h,%h", op.name(), a, b);
		exp  = model(op, a, b);
		axil_write(A_OPA, a, resp);
		check_resp({name, " opa write"}, RESP_OKAY, resp);
		axil_write(A_OPB, b, resp);
		check_resp({name, " opb write"}, RESP_OKAY, resp);
		axil_write(A_OP, W'(op), resp);
		check_resp({name, " op write"}, RESP_OKAY, resp);
		wait_done(status);
		axil_read(A_RESULT, value, resp);
		check_value(name, exp.value, value);
		check_taken({name, " taken"}, exp.taken, status[2]);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic reset_values();
		axil_resp_e   resp;
		logic [W-1:0] data;
		int           e0;
		e0 = errors;
		axil_read(A_STATUS, data, resp);
		check_resp("status read", RESP_OKAY, resp);
		check_taken("status busy", 1'b0, data[0]);
		check_taken("status done", 1'b0, data[1]);
		check_taken("status taken", 1'b0, data[2]);
		axil_read(A_RESULT, data, resp);
		check_value("result after reset", '0, data);
		report_test("reset_values", e0);
	endtask

	task automatic run_group(input string name, input alu_op_e ops [$],
		input logic [W-1:0] ca [$], input logic [W-1:0] cb [$], input int n_rand);
		logic [W-1:0] ra;
		logic [W-1:0] rb;
		int           e0;
		e0 = errors;
		foreach (ops[i]) begin
			foreach (ca[j]) begin
				verify_op(ops[i], ca[j], cb[j]);
			end
			repeat (n_rand) begin
				ra = $random(seed);
				rb = $random(seed);
				verify_op(ops[i], ra, rb);
			end
		end
		report_test(name, e0);
	endtask

	task automatic protocol_errors();
		axil_resp_e   resp;
		alu_res_t     exp;
		logic [W-1:0] status;
		logic [W-1:0] data;
		logic [W-1:0] a;
		int           e0;
		e0  = errors;
		a   = $random(seed);
		exp = model(OP_DIV, a, 32'd7);
		axil_write(A_OPA, a, resp);
		axil_write(A_OPB, 32'd7, resp);
		axil_write(A_OP, W'(OP_DIV), resp);
		check_resp("divide start", RESP_OKAY, resp);
		axil_write(A_OP, W'(OP_REM), resp); // divide still running.
		check_resp("op write while busy", RESP_SLVERR, resp);
		wait_done(status);
		axil_read(A_RESULT, data, resp);
		check_value("divide result after refused op", exp.value, data);
		axil_read(A_OP, data, resp);
		check_value("last op", W'(OP_DIV), data);
		axil_write(A_OP, 32'd24, resp);
		check_resp("undefined opcode", RESP_SLVERR, resp);
		axil_write(A_OP, 32'h0000_0100, resp);
		check_resp("opcode upper bits", RESP_SLVERR, resp);
		axil_read(8'h14, data, resp);
		check_resp("unmapped read 0x14", RESP_SLVERR, resp);
		axil_read(8'hfc, data, resp);
		check_resp("unmapped read 0xfc", RESP_SLVERR, resp);
		report_test("protocol_errors", e0);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		seed    = 65;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		arst_n  = 1'b0;
		aw      = '0;
		awvalid = 1'b0;
		w       = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		ar      = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		reset_values();
		run_group("single_cycle_ops",
			'{OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU},
			'{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678},
			'{32'h0, 32'h1, 32'hffff_ffff, 32'h1, 32'h0000_001f}, 3);
		run_group("branch_ops",
			'{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU},
			'{32'h5, 32'hffff_ffff, 32'h1, 32'hffff_ffff, 32'h2, 32'h1, 32'h8000_0000},
			'{32'h5, 32'hffff_ffff, 32'h2, 32'h1, 32'h1, 32'hffff_ffff, 32'h7fff_ffff}, 0);
		run_group("multiply_ops",
			'{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU},
			'{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff},
			'{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h2}, 3);
		run_group("divide_ops",
			'{OP_DIV, OP_DIVU, OP_REM, OP_REMU},
			'{32'h1234_5678, 32'h8000_0000, 32'hffff_fff9, 32'h7, 32'hffff_ffff},
			'{32'h0, 32'hffff_ffff, 32'h2, 32'hffff_fffe, 32'h3}, 3);
		protocol_errors();

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, checks, errors, u_dut.u_asserts.fails);
		if (errors == 0 && u_dut.u_asserts.fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- tb/alu_asserts.sv
`timescale 1ns/1ps

module alu_asserts (
	input logic clk,
	input logic arst_n,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic start,
	input logic busy,
	input logic done
);

	int unsigned fails = 0;

	property valid_held(v, rdy);
		@(posedge clk) disable iff (!arst_n) v && !rdy |=> v;
	endproperty

	// ------------------------------------------------------------
	// channel handshakes
	// ------------------------------------------------------------
	aw_hold: assert property (valid_held(awvalid, awready))
		else begin
			fails++;
			$error("awvalid dropped before awready");
		end
	w_hold: assert property (valid_held(wvalid, wready))
		else begin
			fails++;
			$error("wvalid dropped before wready");
		end
	b_hold: assert property (valid_held(bvalid, bready))
		else begin
			fails++;
			$error("bvalid dropped before bready");
		end
	ar_hold: assert property (valid_held(arvalid, arready))
		else begin
			fails++;
			$error("arvalid dropped before arready");
		end
	r_hold: assert property (valid_held(rvalid, rready))
		else begin
			fails++;
			$error("rvalid dropped before rready");
		end

	// ------------------------------------------------------------
	// alu request and completion
	// ------------------------------------------------------------
	start_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
		else begin
			fails++;
			$error("start while alu busy");
		end
	done_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> busy)
		else begin
			fails++;
			$error("done while alu idle");
		end
	reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !bvalid && !rvalid)
		else begin
			fails++;
			$error("response valid right after reset");
		end

endmodule

bind alu_top alu_asserts u_asserts (
	.clk     (clk),
	.arst_n  (arst_n),
	.awvalid (awvalid),
	.awready (awready),
	.wvalid  (wvalid),
	.wready  (wready),
	.bvalid  (bvalid),
	.bready  (bready),
	.arvalid (arvalid),
	.arready (arready),
	.rvalid  (rvalid),
	.rready  (rready),
	.start   (start),
	.busy    (busy),
	.done    (done)
);

//--- hw/alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_pkg::*; import axil_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready
);

	alu_req_t req;
	alu_res_t res;
	logic     start;
	logic     busy;
	logic     done;

	alu_regs u_alu_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready),
		.req     (req),
		.start   (start),
		.busy    (busy),
		.done    (done),
		.res     (res)
	);

	alu u_alu (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.start  (start),
		.busy   (busy),
		.done   (done),
		.res    (res)
	);

endmodule

//--- hw/alu_regs.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_regs import alu_pkg::*; import axil_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready,
	output alu_req_t req,
	output logic     start,
	input  logic     busy,
	input  logic     done,
	input  alu_res_t res
);

	localparam logic [`AXIL_AW-1:0] ADDR_OPA    = 'h00;
	localparam logic [`AXIL_AW-1:0] ADDR_OPB    = 'h04;
	localparam logic [`AXIL_AW-1:0] ADDR_OP     = 'h08;
	localparam logic [`AXIL_AW-1:0] ADDR_STATUS = 'h0C;
	localparam logic [`AXIL_AW-1:0] ADDR_RESULT = 'h10;
	localparam int OPW = $bits(alu_op_e);

	logic [`ALU_XLEN-1:0] opa;
	logic [`ALU_XLEN-1:0] opb;
	logic [`ALU_XLEN-1:0] result;
	alu_op_e              op_q;
	logic                 done_q;
	logic                 taken_q;
	logic                 wr_fire;
	logic                 rd_fire;
	logic                 alu_busy;
	logic                 op_legal;
	axil_resp_e           wr_resp;
	logic [AXIL_DW-1:0]   rd_data;
	axil_resp_e           rd_resp;

	function automatic logic [AXIL_DW-1:0] merge(logic [AXIL_DW-1:0] old, axil_w_t wr);
		logic [AXIL_DW-1:0] val;
		val = old;
		for (int i = 0; i < AXIL_SW; i++) begin
			if (wr.strb[i]) begin
				val[8*i +: 8] = wr.data[8*i +: 8];
			end
		end
		return val;
	endfunction

	assign wr_fire  = awvalid & wvalid & ~bvalid; // aw and w taken together.
	assign awready  = wr_fire;
	assign wready   = wr_fire;
	assign rd_fire  = arvalid & ~rvalid;
	assign arready  = rd_fire;
	assign alu_busy = busy | start;
	assign op_legal = (w.data[AXIL_DW-1:OPW] == '0) && (w.data[OPW-1:0] <= OP_BGEU);
	assign req      = '{op: op_q, a: opa, b: opb};

	// ------------------------------------------------------------
	// write path
	// ------------------------------------------------------------
	always_comb begin
		wr_resp = RESP_SLVERR;
		case (aw.addr)
			ADDR_OPA, ADDR_OPB: wr_resp = RESP_OKAY;
			ADDR_OP: wr_resp = (op_legal && !alu_busy) ? RESP_OKAY : RESP_SLVERR;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			opa     <= '0;
			opb     <= '0;
			op_q    <= OP_ADD;
			start   <= 1'b0;
			bvalid  <= 1'b0;
			b       <= '0;
			done_q  <= 1'b0;
			taken_q <= 1'b0;
			result  <= '0;
		end else begin
			start <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
				b.resp <= wr_resp;
				if (wr_resp == RESP_OKAY) begin
					case (aw.addr)
						ADDR_OPA: opa <= merge(opa, w);
						ADDR_OPB: opb <= merge(opb, w);
						default: begin // legal op write.
							op_q   <= alu_op_e'(w.data[OPW-1:0]);
							start  <= 1'b1;
							done_q <= 1'b0;
						end
					endcase
				end
			end
			if (done) begin
				done_q  <= 1'b1;
				taken_q <= res.taken;
				result  <= res.value;
			end
		end
	end

	// ------------------------------------------------------------
	// read path
	// ------------------------------------------------------------
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (ar.addr)
			ADDR_OPA: rd_data = opa;
			ADDR_OPB: rd_data = opb;
			ADDR_OP: rd_data = {{(AXIL_DW-OPW){1'b0}}, op_q};
			ADDR_STATUS: rd_data = {{(AXIL_DW-3){1'b0}}, taken_q, done_q, alu_busy};
			ADDR_RESULT: rd_data = result;
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			r      <= '0;
		end else begin
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (rd_fire) begin
				rvalid <= 1'b1;
				r      <= '{data: rd_data, resp: rd_resp};
			end
		end
	end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu import alu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  alu_req_t req,
	input  logic     start,
	output logic     busy,
	output logic     done,
	output alu_res_t res
);

	localparam int W = `ALU_XLEN;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL_WAIT,
		ST_DIV_RUN,
		ST_DIV_FIX
	} state_e;

	state_e              state;
	alu_req_t            req_q;
	logic [4:0]          cnt;
	alu_class_e          cls;
	logic                sub_like;
	logic                uns_cmp;
	logic [W:0]          a_ext;
	logic [W:0]          b_ext;
	logic [W:0]          sum;
	logic                eq;
	logic                lt;
	logic [`ALU_SHW-1:0] sh;
	logic [W-1:0]        one_val;
	logic                one_taken;
	mul_mode_e           mode;
	logic [2*W-1:0]      prod;
	logic [W-1:0]        mul_val;
	logic [W-1:0]        quot;
	logic [W-1:0]        remd;
	logic                div_init;
	logic                div_step;
	logic                div_last;
	logic                div_zero;
	logic                div_ovf;
	logic [W-1:0]        div_val;

	assign cls = op_class(req.op);

	// ------------------------------------------------------------
	// shared adder, logic, shifter, compare
	// ------------------------------------------------------------
	assign sub_like = req.op inside {OP_SUB, OP_SLT, OP_SLTU, OP_BEQ, OP_BNE,
		OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
	assign uns_cmp  = req.op inside {OP_SLTU, OP_BLTU, OP_BGEU};
	assign a_ext    = {~uns_cmp & req.a[W-1], req.a};
	assign b_ext    = {~uns_cmp & req.b[W-1], req.b} ^ {(W+1){sub_like}};
	assign sum      = a_ext + b_ext + {{W{1'b0}}, sub_like};
	assign eq       = (sum[W-1:0] == '0);
	assign lt       = sum[W]; // sign of the 33 bit difference.
	assign sh       = req.b[`ALU_SHW-1:0];

	always_comb begin
		one_val   = '0; // branches return zero.
		one_taken = 1'b0;
		case (req.op)
			OP_ADD, OP_SUB: one_val = sum[W-1:0];
			OP_SLL: one_val = req.a << sh;
			OP_SRL: one_val = req.a >> sh;
			OP_SRA: one_val = $signed(req.a) >>> sh;
			OP_AND: one_val = req.a & req.b;
			OP_OR: one_val = req.a | req.b;
			OP_XOR: one_val = req.a ^ req.b;
			OP_SLT, OP_SLTU: one_val = {{(W-1){1'b0}}, lt};
			OP_BEQ: one_taken = eq;
			OP_BNE: one_taken = ~eq;
			OP_BLT, OP_BLTU: one_taken = lt;
			OP_BGE, OP_BGEU: one_taken = ~lt;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// multiply and divide
	// ------------------------------------------------------------
	assign mode = (req.op == OP_MULHU) ? MUL_UU :
		(req.op == OP_MULHSU) ? MUL_SU : MUL_SS;

	multi u_multi (
		.clk    (clk),
		.arst_n (arst_n),
		.a      (req.a),
		.b      (req.b),
		.mode   (mode),
		.prod   (prod)
	);

	assign mul_val  = (req_q.op == OP_MUL) ? prod[W-1:0] : prod[2*W-1:W];
	assign div_init = start & (cls == CLS_DIV);
	assign div_step = (state == ST_DIV_RUN);
	assign div_last = div_step & (cnt == 5'(W-1));

	long_div u_long_div (
		.clk      (clk),
		.arst_n   (arst_n),
		.dividend (req.a),
		.divisor  (req.b),
		.unsign   (req.op inside {OP_DIVU, OP_REMU}),
		.init     (div_init),
		.step     (div_step),
		.last     (div_last),
		.quot     (quot),
		.remd     (remd)
	);

	assign div_zero = (req_q.b == '0);
	assign div_ovf  = (req_q.op inside {OP_DIV, OP_REM}) &&
		(req_q.a == {1'b1, {(W-1){1'b0}}}) && (&req_q.b);

	always_comb begin
		if (req_q.op inside {OP_REM, OP_REMU}) begin
			div_val = div_zero ? req_q.a : (div_ovf ? '0 : remd);
		end else begin
			div_val = div_zero ? '1 : (div_ovf ? req_q.a : quot);
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= req;
		end
	end

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			cnt   <= '0;
			busy  <= 1'b0;
			done  <= 1'b0;
			res   <= '0;
		end else begin
			done <= 1'b0;
			if (done) begin
				busy <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						busy <= 1'b1;
						cnt  <= '0;
						if (cls == CLS_MUL) begin
							state <= ST_MUL_WAIT;
						end else if (cls == CLS_DIV) begin
							state <= ST_DIV_RUN; // init happened this cycle.
						end else begin
							done <= 1'b1;
							res  <= '{value: one_val, taken: one_taken};
						end
					end
				end
				ST_MUL_WAIT: begin
					cnt <= cnt + 5'd1;
					if (cnt == 5'(`ALU_MUL_STAGES - 1)) begin
						state <= ST_IDLE;
						done  <= 1'b1;
						res   <= '{value: mul_val, taken: 1'b0};
					end
				end
				ST_DIV_RUN: begin
					cnt <= cnt + 5'd1;
					if (div_last) begin
						state <= ST_DIV_FIX;
					end
				end
				default: begin // divide fix-up.
					state <= ST_IDLE;
					done  <= 1'b1;
					res   <= '{value: div_val, taken: 1'b0};
				end
			endcase
		end
	end

endmodule

//--- hw/multi.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module multi import alu_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`ALU_XLEN-1:0]   a,
	input  logic [`ALU_XLEN-1:0]   b,
	input  mul_mode_e              mode,
	output logic [2*`ALU_XLEN-1:0] prod
);

	localparam int W = `ALU_XLEN;

	logic signed [W:0]     a_ext;
	logic signed [W:0]     b_ext;
	logic signed [2*W+1:0] full;
	logic [2*W-1:0]        pipe [`ALU_MUL_STAGES];

	// 33 bit operands cover every sign mix.
	always_comb begin
		a_ext = {(mode != MUL_UU) & a[W-1], a};
		b_ext = {(mode == MUL_SS) & b[W-1], b};
	end

	assign full = a_ext * b_ext;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `ALU_MUL_STAGES; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= full[2*W-1:0]; // top two bits are sign copies.
			for (int i = 1; i < `ALU_MUL_STAGES; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign prod = pipe[`ALU_MUL_STAGES-1];

endmodule

//--- hw/long_div.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module long_div (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [`ALU_XLEN-1:0] dividend,
	input  logic [`ALU_XLEN-1:0] divisor,
	input  logic                 unsign,
	input  logic                 init,
	input  logic                 step,
	input  logic                 last,
	output logic [`ALU_XLEN-1:0] quot,
	output logic [`ALU_XLEN-1:0] remd
);

	localparam int W = `ALU_XLEN;

	logic [W-1:0] q; // dividend bits out, quotient bits in.
	logic [W-1:0] r;
	logic [W-1:0] dvs;
	logic         neg_q;
	logic         neg_r;
	logic         dvd_neg;
	logic         dvs_neg;
	logic [W:0]   trial;
	logic [W:0]   diff;
	logic [W-1:0] q_next;
	logic [W-1:0] r_next;

	assign dvd_neg = ~unsign & dividend[W-1];
	assign dvs_neg = ~unsign & divisor[W-1];

	// ------------------------------------------------------------
	// one restoring step
	// ------------------------------------------------------------
	always_comb begin
		trial = {r, q[W-1]};
		diff  = trial - {1'b0, dvs};
		if (diff[W]) begin // negative, restore.
			r_next = trial[W-1:0];
			q_next = {q[W-2:0], 1'b0};
		end else begin
			r_next = diff[W-1:0];
			q_next = {q[W-2:0], 1'b1};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q     <= '0;
			r     <= '0;
			dvs   <= '0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
		end else if (init) begin
			q     <= dvd_neg ? -dividend : dividend;
			r     <= '0;
			dvs   <= dvs_neg ? -divisor : divisor;
			neg_q <= dvd_neg ^ dvs_neg;
			neg_r <= dvd_neg; // remainder takes the dividend sign.
		end else if (step) begin
			q <= (last && neg_q) ? -q_next : q_next;
			r <= (last && neg_r) ? -r_next : r_next;
		end
	end

	assign quot = q;
	assign remd = r;

endmodule

//--- hw/axil_pkg.sv
`include "alu_config.svh"

package axil_pkg;

	localparam int AXIL_DW = 32;
	localparam int AXIL_SW = AXIL_DW / 8;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// ------------------------------------------------------------
	// channel payloads, handshakes travel beside them
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`AXIL_AW-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [AXIL_DW-1:0] data;
		logic [AXIL_SW-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic [`AXIL_AW-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [AXIL_DW-1:0] data;
		axil_resp_e         resp;
	} axil_r_t;

endpackage

//--- hw/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

	typedef enum logic [4:0] {
		OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA, // 0..4
		OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, // 5..9
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, // 10..13
		OP_DIV, OP_DIVU, OP_REM, OP_REMU, // 14..17
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU // 18..23
	} alu_op_e;

	typedef enum logic [1:0] {
		CLS_SINGLE,
		CLS_MUL,
		CLS_DIV
	} alu_class_e;

	typedef enum logic [1:0] {
		MUL_SS,
		MUL_SU, // a signed, b unsigned.
		MUL_UU
	} mul_mode_e;

	typedef struct packed {
		alu_op_e              op;
		logic [`ALU_XLEN-1:0] a;
		logic [`ALU_XLEN-1:0] b;
	} alu_req_t;

	typedef struct packed {
		logic [`ALU_XLEN-1:0] value;
		logic                 taken;
	} alu_res_t;

	function automatic alu_class_e op_class(alu_op_e op);
		case (op)
			OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return CLS_MUL;
			OP_DIV, OP_DIVU, OP_REM, OP_REMU: return CLS_DIV;
			default: return CLS_SINGLE;
		endcase
	endfunction

endpackage

//--- hw/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------
`define ALU_XLEN 32 // operand width.
`define ALU_SHW 5 // shift amount bits.
`define ALU_MUL_STAGES 2 // multiplier latency.

// ------------------------------------------------------------
// host bus
// ------------------------------------------------------------
`define AXIL_AW 8

`endif
